//--- rtl/evmap_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// event buffer memory map
//////////////////////////////////////////////////
package evmap_pkg;

    // offsets inside one event are kept in kilobytes
    // 9 bits covers base offset plus 28 chunks of 4 kB
    typedef logic [8:0] addr_kb_t;

    // event address is DDR address bits 31:19
    // so the full 4 GB space fits in 13 bits
    typedef logic [12:0] done_addr_t;

    // one chunk of one SURF
    localparam int CHUNK_SIZE_KB = 4;

    // chunk counts per event
    localparam int N_SURF = 7;
    localparam int N_CHUNK = 4;

    // each SURF owns all of its chunks back to back
    localparam int SURF_SIZE_KB = N_CHUNK * CHUNK_SIZE_KB;

    // bytes per DataMover command, always a full chunk
    localparam int CHUNK_BTT = CHUNK_SIZE_KB * 1024;

    // tag carried with every payload beat
    typedef struct packed {
        logic [2:0] surf;
        logic [1:0] chunk;
    } ident_t;

endpackage

`default_nettype wire

//--- rtl/evfmt_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// stream formats
//////////////////////////////////////////////////
package evfmt_pkg;

    // command FIFO entry, address bits 9:0 are always zero so they are not stored
    typedef struct packed {
        logic                  last;
        evmap_pkg::done_addr_t done_addr;
        evmap_pkg::addr_kb_t   chunk_kb;
    } cmd_entry_t;

    // lower command flags of the DataMover
    typedef struct packed {
        logic       drr;
        logic       eof;
        logic [5:0] dsa;
        logic       incr;
    } dm_flags_t;

    // 72-bit DataMover command, no user or cache byte
    // tag bit 0 marks the final command of an event
    typedef struct packed {
        logic [7:0]  tag;
        logic [31:0] addr;
        dm_flags_t   flags;
        logic [22:0] btt;
    } dm_cmd_t;

    // DataMover status byte
    typedef struct packed {
        logic       okay;
        logic [2:0] err;
        logic [2:0] rsvd;
        logic       last;
    } dm_stat_t;

    // per-event error summary
    // one bit per chunk transfer plus 4 sticky class bits
    typedef struct packed {
        logic        last_err;
        logic [26:0] xfer_err;
        logic [3:0]  class_err;
    } err_word_t;

    typedef struct packed {
        evmap_pkg::done_addr_t done_addr;
        err_word_t             err_word;
    } cmpl_entry_t;

    // sticky faults, listed MSB first so cmd_ovf lands on bit 0
    typedef struct packed {
        logic done_unf;
        logic cmpl_ovf;
        logic done_ovf;
        logic cmd_ovf;
    } fault_t;

endpackage

`default_nettype wire

//--- rtl/event_fifo.sv
`timescale 1ns/10ps
`default_nettype none

// first-word-fall-through FIFO
// head entry sits on dout_o whenever valid_o is high
module event_fifo #(
    parameter int  DEPTH  = 8,
    parameter type item_t = logic [7:0]
) (
    input  wire logic  memclk,
    input  wire logic  memresetn,
    input  wire logic  wr_i,
    input  wire item_t din_i,
    input  wire logic  rd_i,
    output item_t      dout_o,
    output logic       valid_o,
    output logic       ovf_o,
    output logic       unf_o
);

    localparam int AW = $clog2(DEPTH);

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full = (count == (AW+1)'(DEPTH));
    assign valid_o = (count != '0);
    // a read in the same cycle frees the slot for a write into a full FIFO
    assign do_rd = rd_i && valid_o;
    assign do_wr = wr_i && (!full || do_rd);
    // error pulses
    assign ovf_o = wr_i && !do_wr;
    assign unf_o = rd_i && !valid_o;
    assign dout_o = mem[rd_ptr];

    always_ff @(posedge memclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/chunk_addr_seq.sv
`timescale 1ns/10ps
`default_nettype none

// turns finished SURF chunks into command FIFO entries
// chunks come in order: chunk 0 SURF 0..6, chunk 1 SURF 0..6 and so on
module chunk_addr_seq #(
    parameter logic [6:0] BASE_ADDRESS_4KB = 7'd4
) (
    input  wire logic                  memclk,
    input  wire logic                  memresetn,
    input  wire logic                  payload_valid_i,
    input  wire logic                  payload_last_i,
    input  wire evmap_pkg::ident_t     payload_ident_i,
    input  wire logic                  done_valid_i,
    input  wire evmap_pkg::done_addr_t done_i,
    output logic                       cmd_wr_o,
    output evfmt_pkg::cmd_entry_t      cmd_entry_o,
    output logic                       done_wr_o,
    output logic                       done_ready_o,
    output logic                       payload_has_space_o
);

    typedef enum logic [1:0] {IDLE, LOAD, WAIT, INCR} state_t;

    localparam logic [2:0] LAST_SURF = 3'(evmap_pkg::N_SURF - 1);
    localparam logic [1:0] LAST_CHUNK = 2'(evmap_pkg::N_CHUNK - 1);
    // base offset expanded from 4 kB to 1 kB units
    localparam evmap_pkg::addr_kb_t BASE_KB = {BASE_ADDRESS_4KB, 2'b00};

    state_t              state;
    logic [1:0]          chunk_q;
    evmap_pkg::addr_kb_t chunk_base;
    evmap_pkg::addr_kb_t addend_a;
    evmap_pkg::addr_kb_t addend_b;
    evmap_pkg::addr_kb_t this_addr;
    logic                beat_last;
    logic                surf_end;
    logic                event_end;

    // end of a SURF chunk, only looked at while waiting for it
    assign beat_last = (state == WAIT) && payload_valid_i && payload_last_i;
    assign surf_end = (payload_ident_i.surf == LAST_SURF);
    assign event_end = surf_end && (payload_ident_i.chunk == LAST_CHUNK);

    // start of each chunk row, only 4 possible values
    assign chunk_base = BASE_KB
        + evmap_pkg::addr_kb_t'(chunk_q) * evmap_pkg::addr_kb_t'(evmap_pkg::CHUNK_SIZE_KB);

    //////////////////////////////////////////////////
    // single adder
    //////////////////////////////////////////////////
    // LOAD: 0 + chunk base
    // INCR: held address + one SURF
    assign addend_a = (state == INCR) ? this_addr : '0;
    assign addend_b = (state == LOAD) ? chunk_base
                                      : evmap_pkg::addr_kb_t'(evmap_pkg::SURF_SIZE_KB);

    always_ff @(posedge memclk) begin
        if (state == LOAD || state == INCR) begin
            this_addr <= addend_a + addend_b;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state <= IDLE;
            chunk_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    chunk_q <= '0;
                    // need an event address before the first chunk can be placed
                    if (payload_valid_i && done_valid_i) state <= LOAD;
                end
                LOAD: state <= WAIT;
                WAIT: begin
                    if (beat_last) begin
                        if (event_end) begin
                            state <= IDLE;
                        end else if (surf_end) begin
                            // next chunk row starts over at SURF 0
                            chunk_q <= chunk_q + 2'd1;
                            state <= LOAD;
                        end else begin
                            state <= INCR;
                        end
                    end
                end
                INCR: state <= WAIT;
                default: state <= IDLE;
            endcase
        end
    end

    assign cmd_wr_o = beat_last;
    assign cmd_entry_o.last = event_end;
    assign cmd_entry_o.done_addr = done_i;
    assign cmd_entry_o.chunk_kb = this_addr;

    // the event address is consumed together with its final command
    assign done_wr_o = beat_last && event_end;
    assign done_ready_o = done_wr_o;

    assign payload_has_space_o = (state == IDLE) && done_valid_i;

endmodule

`default_nettype wire

//--- rtl/status_tracker.sv
`timescale 1ns/10ps
`default_nettype none

// folds DataMover status bytes into one error word per event
module status_tracker (
    input  wire logic                  memclk,
    input  wire logic                  memresetn,
    input  wire logic                  stat_valid_i,
    input  wire evfmt_pkg::dm_stat_t   stat_i,
    input  wire evmap_pkg::done_addr_t done_addr_i,
    output logic                       done_rd_o,
    output logic                       cmpl_wr_o,
    output evfmt_pkg::cmpl_entry_t     cmpl_entry_o
);

    evfmt_pkg::err_word_t err_word;
    logic [3:0]           cur_class;
    logic [3:0]           class_q;
    logic [26:0]          xfer_q;
    logic                 any_err;
    logic                 last_stat;

    // status recast as pure errors, not-okay on top
    assign cur_class = {~stat_i.okay, stat_i.err};
    assign any_err = |cur_class;
    assign last_stat = stat_valid_i && stat_i.last;

    // the final transfer never enters the shift register, it goes straight to bit 31
    assign err_word.last_err = any_err;
    assign err_word.xfer_err = xfer_q;
    assign err_word.class_err = class_q | cur_class;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            class_q <= '0;
            xfer_q <= '0;
        end else if (stat_valid_i) begin
            // sticky classes restart with each event
            class_q <= stat_i.last ? 4'h0 : (class_q | cur_class);
            // oldest transfer drifts down to bit 0
            xfer_q <= {any_err, xfer_q[26:1]};
        end
    end

    // done address FIFO head belongs to the event now finishing
    assign done_rd_o = last_stat;
    assign cmpl_wr_o = last_stat;
    assign cmpl_entry_o.done_addr = done_addr_i;
    assign cmpl_entry_o.err_word = err_word;

endmodule

`default_nettype wire

//--- rtl/event_req_gen.sv
`timescale 1ns/10ps
`default_nettype none

// write request generator for the DDR event buffer
module event_req_gen #(
    parameter logic [6:0] BASE_ADDRESS_4KB = 7'd4,
    parameter int         CMD_DEPTH = 32,
    parameter int         DONE_DEPTH = 8,
    parameter int         CMPL_DEPTH = 8
) (
    input  wire logic                  memclk,
    input  wire logic                  memresetn,
    input  wire logic                  payload_valid_i,
    input  wire logic                  payload_last_i,
    input  wire evmap_pkg::ident_t     payload_ident_i,
    output logic                       payload_has_space_o,
    input  wire logic                  done_valid_i,
    input  wire evmap_pkg::done_addr_t done_i,
    output logic                       done_ready_o,
    output logic                       cmd_valid_o,
    input  wire logic                  cmd_ready_i,
    output evfmt_pkg::dm_cmd_t         cmd_o,
    input  wire logic                  stat_valid_i,
    input  wire evfmt_pkg::dm_stat_t   stat_i,
    output logic                       cmpl_valid_o,
    input  wire logic                  cmpl_ready_i,
    output logic [63:0]                cmpl_o,
    output evfmt_pkg::fault_t          cmd_err_o
);

    evfmt_pkg::cmd_entry_t  cmd_wr_entry;
    evfmt_pkg::cmd_entry_t  cmd_head;
    evfmt_pkg::cmpl_entry_t cmpl_wr_entry;
    evfmt_pkg::cmpl_entry_t cmpl_head;
    evmap_pkg::done_addr_t  done_head;
    logic                   cmd_wr;
    logic                   cmd_ovf;
    logic                   done_wr;
    logic                   done_rd;
    logic                   done_ovf;
    logic                   done_unf;
    logic                   cmpl_wr;
    logic                   cmpl_ovf;

    chunk_addr_seq #(
        .BASE_ADDRESS_4KB(BASE_ADDRESS_4KB)
    ) seq_inst (
        .memclk(memclk),
        .memresetn(memresetn),
        .payload_valid_i(payload_valid_i),
        .payload_last_i(payload_last_i),
        .payload_ident_i(payload_ident_i),
        .done_valid_i(done_valid_i),
        .done_i(done_i),
        .cmd_wr_o(cmd_wr),
        .cmd_entry_o(cmd_wr_entry),
        .done_wr_o(done_wr),
        .done_ready_o(done_ready_o),
        .payload_has_space_o(payload_has_space_o)
    );

    //////////////////////////////////////////////////
    // FIFOs
    //////////////////////////////////////////////////
    // commands, popped by the DataMover
    event_fifo #(
        .DEPTH(CMD_DEPTH),
        .item_t(evfmt_pkg::cmd_entry_t)
    ) cmd_fifo_inst (
        .memclk(memclk),
        .memresetn(memresetn),
        .wr_i(cmd_wr),
        .din_i(cmd_wr_entry),
        .rd_i(cmd_valid_o && cmd_ready_i),
        .dout_o(cmd_head),
        .valid_o(cmd_valid_o),
        .ovf_o(cmd_ovf),
        .unf_o()
    );

    // event addresses waiting for their last status
    event_fifo #(
        .DEPTH(DONE_DEPTH),
        .item_t(evmap_pkg::done_addr_t)
    ) done_fifo_inst (
        .memclk(memclk),
        .memresetn(memresetn),
        .wr_i(done_wr),
        .din_i(done_i),
        .rd_i(done_rd),
        .dout_o(done_head),
        .valid_o(),
        .ovf_o(done_ovf),
        .unf_o(done_unf)
    );

    // completions, popped by the outside
    event_fifo #(
        .DEPTH(CMPL_DEPTH),
        .item_t(evfmt_pkg::cmpl_entry_t)
    ) cmpl_fifo_inst (
        .memclk(memclk),
        .memresetn(memresetn),
        .wr_i(cmpl_wr),
        .din_i(cmpl_wr_entry),
        .rd_i(cmpl_valid_o && cmpl_ready_i),
        .dout_o(cmpl_head),
        .valid_o(cmpl_valid_o),
        .ovf_o(cmpl_ovf),
        .unf_o()
    );

    status_tracker stat_inst (
        .memclk(memclk),
        .memresetn(memresetn),
        .stat_valid_i(stat_valid_i),
        .stat_i(stat_i),
        .done_addr_i(done_head),
        .done_rd_o(done_rd),
        .cmpl_wr_o(cmpl_wr),
        .cmpl_entry_o(cmpl_wr_entry)
    );

    // only the address and the last tag change between commands
    // incrementing burst with tlast expected, no realignment
    always_comb begin
        cmd_o.tag = {7'd0, cmd_head.last};
        cmd_o.addr = {cmd_head.done_addr, cmd_head.chunk_kb, 10'd0};
        cmd_o.flags.drr = 1'b0;
        cmd_o.flags.eof = 1'b1;
        cmd_o.flags.dsa = 6'd0;
        cmd_o.flags.incr = 1'b1;
        cmd_o.btt = 23'(evmap_pkg::CHUNK_BTT);
    end

    assign cmpl_o = {19'd0, cmpl_head};

    // sticky fault flags, cleared only by reset
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            cmd_err_o <= '0;
        end else begin
            if (cmd_ovf) cmd_err_o.cmd_ovf <= 1'b1;
            if (done_ovf) cmd_err_o.done_ovf <= 1'b1;
            if (cmpl_ovf) cmd_err_o.cmpl_ovf <= 1'b1;
            if (done_unf) cmd_err_o.done_unf <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

// memory clock and synchronous reset for the testbench
module tb_clkgen #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic memclk_o,
    output logic memresetn_o
);

    initial begin
        memclk_o = 1'b0;
        forever #(PERIOD_NS / 2) memclk_o = ~memclk_o;
    end

    // reset released just after a rising edge, like the other stimulus
    initial begin
        memresetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge memclk_o);
        #2;
        memresetn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/event_req_gen_sva.sv
`timescale 1ns/10ps
`default_nettype none

// protocol rules on the top level ports
module event_req_gen_sva (
    input wire logic        memclk,
    input wire logic        memresetn,
    input wire logic        cmd_valid_o,
    input wire logic        cmd_ready_i,
    input wire logic [71:0] cmd_o,
    input wire logic        cmpl_valid_o,
    input wire logic        cmpl_ready_i,
    input wire logic [63:0] cmpl_o,
    input wire logic [3:0]  cmd_err_o,
    input wire logic        done_valid_i,
    input wire logic        done_ready_o
);

    // a stalled command holds still until taken
    cmd_hold: assert property (@(posedge memclk) disable iff (!memresetn)
        cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o))
        else $error("command changed while stalled");

    // same for completions
    cmpl_hold: assert property (@(posedge memclk) disable iff (!memresetn)
        cmpl_valid_o && !cmpl_ready_i |=> cmpl_valid_o && $stable(cmpl_o))
        else $error("completion changed while stalled");

    // sticky faults only clear through reset
    err_sticky: assert property (@(posedge memclk) disable iff (!memresetn)
        $past(memresetn) |-> ((~cmd_err_o) & $past(cmd_err_o)) == 4'h0)
        else $error("fault flag fell outside reset");

    done_pulse: assert property (@(posedge memclk) disable iff (!memresetn)
        done_ready_o |-> done_valid_i)
        else $error("done_ready_o without done_valid_i");

endmodule

bind event_req_gen event_req_gen_sva sva_inst (
    .memclk(memclk),
    .memresetn(memresetn),
    .cmd_valid_o(cmd_valid_o),
    .cmd_ready_i(cmd_ready_i),
    .cmd_o(cmd_o),
    .cmpl_valid_o(cmpl_valid_o),
    .cmpl_ready_i(cmpl_ready_i),
    .cmpl_o(cmpl_o),
    .cmd_err_o(cmd_err_o),
    .done_valid_i(done_valid_i),
    .done_ready_o(done_ready_o)
);

`default_nettype wire

//--- verif/event_req_gen_tb.sv
`timescale 1ns/10ps
`default_nettype none

module event_req_gen_tb;

    localparam logic [6:0] BASE_4KB = 7'd4;
    localparam int TIMEOUT = 4000;

    logic                   memclk;
    logic                   memresetn;
    logic                   payload_valid_i;
    logic                   payload_last_i;
    evmap_pkg::ident_t      payload_ident_i;
    logic                   payload_has_space_o;
    logic                   done_valid_i;
    evmap_pkg::done_addr_t  done_i;
    logic                   done_ready_o;
    logic                   cmd_valid_o;
    logic                   cmd_ready_i;
    evfmt_pkg::dm_cmd_t     cmd_o;
    logic                   stat_valid_i;
    evfmt_pkg::dm_stat_t    stat_i;
    logic                   cmpl_valid_o;
    logic                   cmpl_ready_i;
    logic [63:0]            cmpl_o;
    evfmt_pkg::fault_t      cmd_err_o;

    // expected streams
    logic [31:0]            exp_addr_q[$];
    logic                   exp_last_q[$];
    logic [63:0]            exp_cmpl_q[$];
    evmap_pkg::done_addr_t  event_addr_q[$];
    evfmt_pkg::dm_stat_t    stat_q[$];
    // error word model of the open event
    logic [3:0]             class_acc;
    logic [26:0]            xfer_acc;
    int                     xfer_n;
    // test modes
    logic                   check_cmds;
    logic                   check_cmpl;
    logic                   dm_enable;
    logic                   inject_errors;
    logic                   random_ready;
    logic                   ready_hold;
    logic                   cmpl_stall;
    logic                   timed_out;
    int                     errors;
    int                     checks;
    int                     done_pulses;

    tb_clkgen clk_inst (
        .memclk_o(memclk),
        .memresetn_o(memresetn)
    );

    event_req_gen #(
        .BASE_ADDRESS_4KB(BASE_4KB)
    ) event_req_gen_inst (.*);

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // kilobyte offset of one chunk inside its event
    function automatic logic [8:0] chunk_kb(input int c, input int s);
        return 9'(4 * int'(BASE_4KB) + 4 * c + 16 * s);
    endfunction

    //////////////////////////////////////////////////
    // mock DataMover
    //////////////////////////////////////////////////
    task automatic dm_status(input logic last);
        evfmt_pkg::dm_stat_t st;
        logic [3:0]          cls;
        st = '{okay: 1'b1, err: 3'd0, rsvd: 3'd0, last: last};
        if (inject_errors && ($urandom % 5) == 0) begin
            st.okay = ($urandom % 2) == 1;
            st.err = 3'($urandom % 8);
            $display("  status injected okay=%0b err=%0d", st.okay, st.err);
        end
        stat_q.push_back(st);
        // transfer k lands on word bit 4+k and the last one on bit 31
        cls = {~st.okay, st.err};
        if (last) begin
            exp_cmpl_q.push_back({19'd0, event_addr_q.pop_front(), |cls, xfer_acc,
                                  class_acc | cls});
            class_acc = '0;
            xfer_acc = '0;
            xfer_n = 0;
        end else begin
            class_acc = class_acc | cls;
            if (xfer_n < 27) xfer_acc[xfer_n] = |cls;
            xfer_n++;
        end
    endtask

    // outputs are settled by mid cycle
    always @(negedge memclk) begin
        if (memresetn) begin
            check_val("payload_has_space_o with done_valid_i low",
                      64'(payload_has_space_o && !done_valid_i), 64'd0);
            if (done_ready_o) done_pulses++;
            if (cmd_valid_o && cmd_ready_i) begin
                if (check_cmds && exp_addr_q.size() == 0) begin
                    $display("unexpected command at time %0t", $time);
                    errors++;
                end else if (check_cmds) begin
                    check_val("cmd_o.addr", 64'(cmd_o.addr), 64'(exp_addr_q.pop_front()));
                    check_val("cmd_o.tag", 64'(cmd_o.tag), 64'({7'd0, exp_last_q.pop_front()}));
                    // DRR 0, EOF 1, DSA 0, TYPE 1, btt one chunk
                    check_val("cmd_o.flags/btt", 64'(cmd_o[31:0]), 64'({9'h081, 23'd4096}));
                end
                if (dm_enable) dm_status(cmd_o.tag[0]);
            end
            if (cmpl_valid_o && cmpl_ready_i && check_cmpl) begin
                if (exp_cmpl_q.size() == 0) begin
                    $display("unexpected completion at time %0t", $time);
                    errors++;
                end else begin
                    check_val("cmpl_o", cmpl_o, exp_cmpl_q.pop_front());
                end
            end
        end
    end

    // status strobes and ready patterns
    always @(posedge memclk) begin
        #2;
        if (stat_q.size() > 0 && ($urandom % 3) != 0) begin
            stat_i = stat_q.pop_front();
            stat_valid_i = 1'b1;
        end else begin
            stat_valid_i = 1'b0;
        end
        cmd_ready_i = random_ready ? (($urandom % 2) == 1) : ready_hold;
        cmpl_ready_i = !cmpl_stall && (($urandom % 4) != 0);
    end

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////
    task automatic send_event(input evmap_pkg::done_addr_t addr, input logic gaps);
        int n;
        int nbeats;
        n = 0;
        done_i = addr;
        done_valid_i = 1'b1;
        while (!payload_has_space_o && n < TIMEOUT) begin
            @(posedge memclk);
            #2;
            n++;
        end
        if (!payload_has_space_o) begin
            $display("payload_has_space_o never rose for event %h", addr);
            timed_out = 1'b1;
            return;
        end
        if (check_cmds) event_addr_q.push_back(addr);
        for (int c = 0; c < 4; c++) begin
            for (int s = 0; s < 7; s++) begin
                if (check_cmds) begin
                    exp_addr_q.push_back({addr, chunk_kb(c, s), 10'd0});
                    exp_last_q.push_back(c == 3 && s == 6);
                end
                nbeats = 3 + int'($urandom % 3);
                for (int b = 0; b < nbeats; b++) begin
                    payload_valid_i = 1'b1;
                    payload_ident_i.surf = 3'(s);
                    payload_ident_i.chunk = 2'(c);
                    payload_last_i = (b == nbeats - 1);
                    @(posedge memclk);
                    #2;
                    payload_valid_i = 1'b0;
                    payload_last_i = 1'b0;
                    if (gaps && ($urandom % 4) == 0) begin
                        @(posedge memclk);
                        #2;
                    end
                end
            end
        end
        done_valid_i = 1'b0;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while ((exp_addr_q.size() + exp_cmpl_q.size() + stat_q.size()) != 0 && n < TIMEOUT) begin
            @(posedge memclk);
            #2;
            n++;
        end
        if ((exp_addr_q.size() + exp_cmpl_q.size() + stat_q.size()) != 0) begin
            $display("traffic still pending after %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_fault(input int bit_idx, input string name);
        int n;
        n = 0;
        while (!cmd_err_o[bit_idx] && n < TIMEOUT) begin
            @(posedge memclk);
            #2;
            n++;
        end
        check_val(name, 64'(cmd_err_o[bit_idx]), 64'd1);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s: %s", name,
                 (errors == err_before && !timed_out) ? "ok" : "FAILED");
    endtask

    initial begin
        int e0;
        int pulses0;
        int n;
        void'($urandom(32'hdc832c02));
        payload_valid_i = 1'b0;
        payload_last_i = 1'b0;
        payload_ident_i = '0;
        done_valid_i = 1'b0;
        done_i = '0;
        cmd_ready_i = 1'b1;
        stat_valid_i = 1'b0;
        stat_i = '0;
        cmpl_ready_i = 1'b1;
        class_acc = '0;
        xfer_acc = '0;
        xfer_n = 0;
        check_cmds = 1'b1;
        check_cmpl = 1'b1;
        dm_enable = 1'b1;
        inject_errors = 1'b0;
        random_ready = 1'b0;
        ready_hold = 1'b1;
        cmpl_stall = 1'b0;
        timed_out = 1'b0;
        errors = 0;
        checks = 0;
        done_pulses = 0;

        // reset values
        e0 = errors;
        n = 0;
        while (memresetn !== 1'b1 && n < 100) begin
            @(posedge memclk);
            #2;
            n++;
        end
        if (memresetn !== 1'b1) begin
            $display("memresetn was never released");
            timed_out = 1'b1;
        end
        check_val("cmd_valid_o", 64'(cmd_valid_o), 64'd0);
        check_val("cmpl_valid_o", 64'(cmpl_valid_o), 64'd0);
        check_val("done_ready_o", 64'(done_ready_o), 64'd0);
        check_val("payload_has_space_o", 64'(payload_has_space_o), 64'd0);
        check_val("cmd_err_o", 64'(cmd_err_o), 64'd0);
        report_test("reset values", e0);

        // command addresses with a random command ready
        e0 = errors;
        random_ready = 1'b1;
        if (!timed_out) send_event(13'h0a5, 1'b1);
        if (!timed_out) send_event(13'h1ff3, 1'b0);
        if (!timed_out) wait_drained("command test");
        report_test("command stream", e0);

        // one done entry per event and no space without a done entry
        e0 = errors;
        pulses0 = done_pulses;
        repeat (10) @(posedge memclk);
        #2;
        if (!timed_out) send_event(13'h0001, 1'b1);
        if (!timed_out) send_event(13'h1000, 1'b1);
        if (!timed_out) wait_drained("done test");
        check_val("done_ready_o pulses", 64'(done_pulses - pulses0), 64'd2);
        report_test("done handshake", e0);

        // error words while completions are held back
        e0 = errors;
        inject_errors = 1'b1;
        cmpl_stall = 1'b1;
        if (!timed_out) send_event(13'h0777, 1'b1);
        if (!timed_out) send_event(13'h0abc, 1'b0);
        if (!timed_out) send_event(13'h1234, 1'b1);
        cmpl_stall = 1'b0;
        if (!timed_out) wait_drained("completion test");
        inject_errors = 1'b0;
        report_test("completions", e0);

        // last status with nothing pending then a blocked command stream
        e0 = errors;
        random_ready = 1'b0;
        check_cmpl = 1'b0;
        stat_q.push_back('{okay: 1'b1, err: 3'd0, rsvd: 3'd0, last: 1'b1});
        if (!timed_out) wait_fault(3, "cmd_err_o.done_unf");
        check_cmds = 1'b0;
        dm_enable = 1'b0;
        ready_hold = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (!timed_out) send_event(13'(16'h0200 + i), 1'b0);
        end
        if (!timed_out) wait_fault(0, "cmd_err_o.cmd_ovf");
        report_test("fault flags", e0);

        if (timed_out) $display("run stopped by a timeout");
        $display("checks run %0d, failed %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/evmap_pkg.sv
rtl/evfmt_pkg.sv
rtl/event_fifo.sv
rtl/chunk_addr_seq.sv
rtl/status_tracker.sv
rtl/event_req_gen.sv
verif/tb_clkgen.sv
verif/event_req_gen_sva.sv
verif/event_req_gen_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module event_req_gen_tb -o sim_event_req_gen

out=$(./obj_dir/sim_event_req_gen)
echo "$out"

grep -q "All checks passed" <<< "$out"
